// File: hdl/lvds_retime_pkg.sv
////////////////////////////////////////////////////////////////////////////
// lvds retimer shared definitions
// lane, word and frame geometry constants
// sample, word and frame types
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package lvds_retime_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // lane and word geometry
   ////////////////////////////////////////////////////////////////////////////
   localparam int LANE_COUNT = 20;
   localparam int LANES_PER_WORD = 5;
   // lane bits plus the zero pad in bit 0
   localparam int WORD_W = LANES_PER_WORD + 1;
   localparam int WORDS_PER_SAMPLE = LANE_COUNT / LANES_PER_WORD;

   ////////////////////////////////////////////////////////////////////////////
   // frame geometry
   ////////////////////////////////////////////////////////////////////////////
   // two samples side by side in one row
   localparam int SAMPLES_PER_ROW = 2;
   localparam int WORDS_PER_ROW = WORDS_PER_SAMPLE * SAMPLES_PER_ROW;
   localparam int HISTORY_DEPTH = 8;
   localparam int ROW_COUNT = HISTORY_DEPTH / SAMPLES_PER_ROW;
   // clocks between two frame loads
   localparam int FRAME_CYCLES = 4;

   ////////////////////////////////////////////////////////////////////////////
   // types
   ////////////////////////////////////////////////////////////////////////////
   // one sample, lane 0 in bit 0
   typedef logic [LANE_COUNT-1:0] lane_vec_t;

   // padded output word
   typedef logic [WORD_W-1:0] word_t;

   // rows of padded words, row 3 holds the newest samples
   typedef word_t [ROW_COUNT-1:0][WORDS_PER_ROW-1:0] frame_words_t;

endpackage

`default_nettype wire

// File: hdl/lane_sampler.sv
////////////////////////////////////////////////////////////////////////////
// lane input register
// frame phase counter and frame load flag
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lane_sampler (
   input  wire                         clk,
   input  wire                         arstb,
   input  wire                         rst_retime,
   input  wire lvds_retime_pkg::lane_vec_t lanes,
   output lvds_retime_pkg::lane_vec_t  sample_new,
   output logic                        frame_load
);

   localparam int FRAME_CYCLES = lvds_retime_pkg::FRAME_CYCLES;
   localparam int PHASE_W = (FRAME_CYCLES > 1) ? $clog2(FRAME_CYCLES) : 1;

   // position inside the current frame
   logic [PHASE_W-1:0] phase;

   ////////////////////////////////////////////////////////////////////////////
   // sample register
   ////////////////////////////////////////////////////////////////////////////
   // all lanes captured together as sample 0
   always_ff @(posedge clk or negedge arstb) begin
      if (!arstb) begin
         sample_new <= '0;
      end else if (!rst_retime) begin
         sample_new <= '0;
      end else begin
         sample_new <= lanes;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // frame phase
   ////////////////////////////////////////////////////////////////////////////
   // held at zero while the retimer is cleared
   always_ff @(posedge clk or negedge arstb) begin
      if (!arstb) begin
         phase <= '0;
      end else if (!rst_retime) begin
         phase <= '0;
      end else if (frame_load) begin
         phase <= '0;
      end else begin
         phase <= phase + 1'b1;
      end
   end

   // last cycle of the phase, packer loads on the next edge
   assign frame_load = (phase == PHASE_W'(FRAME_CYCLES - 1));

endmodule

`default_nettype wire

// File: hdl/sample_history.sv
////////////////////////////////////////////////////////////////////////////
// shift history of the older samples
// one register stage per clock of age
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sample_history #(
   parameter int HISTORY_DEPTH = lvds_retime_pkg::HISTORY_DEPTH
) (
   input  wire                         clk,
   input  wire                         arstb,
   input  wire                         rst_retime,
   input  wire lvds_retime_pkg::lane_vec_t sample_new,
   // element k is the sample k clocks older than sample_new
   output lvds_retime_pkg::lane_vec_t [1:HISTORY_DEPTH-1] sample_old
);

   ////////////////////////////////////////////////////////////////////////////
   // shift chain
   ////////////////////////////////////////////////////////////////////////////
   // every stage moves one step older each clock
   always_ff @(posedge clk or negedge arstb) begin
      if (!arstb) begin
         sample_old <= '0;
      end else if (!rst_retime) begin
         // empty history, next frames start from zeros
         sample_old <= '0;
      end else begin
         sample_old[1] <= sample_new;
         for (int i = 2; i < HISTORY_DEPTH; i++) begin
            sample_old[i] <= sample_old[i-1];
         end
      end
   end

endmodule

`default_nettype wire

// File: hdl/frame_packer.sv
////////////////////////////////////////////////////////////////////////////
// repacks the sample history into padded output words
// output word register and frame strobe
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module frame_packer #(
   parameter int HISTORY_DEPTH = lvds_retime_pkg::HISTORY_DEPTH
) (
   input  wire                         clk,
   input  wire                         arstb,
   input  wire lvds_retime_pkg::lane_vec_t sample_new,
   input  wire lvds_retime_pkg::lane_vec_t [1:HISTORY_DEPTH-1] sample_old,
   input  wire                         frame_load,
   output lvds_retime_pkg::frame_words_t frame_words,
   output logic                        frame_strobe
);

   localparam int LPW = lvds_retime_pkg::LANES_PER_WORD;
   localparam int WPS = lvds_retime_pkg::WORDS_PER_SAMPLE;
   localparam int SPR = lvds_retime_pkg::SAMPLES_PER_ROW;
   localparam int ROWS = HISTORY_DEPTH / SPR;

   // whole history, element 0 is the newest sample
   lvds_retime_pkg::lane_vec_t [0:HISTORY_DEPTH-1] hist;
   lvds_retime_pkg::frame_words_t frame_next;

   assign hist = {sample_new, sample_old};

   ////////////////////////////////////////////////////////////////////////////
   // packing
   ////////////////////////////////////////////////////////////////////////////
   // row r holds the pair of samples SPR*(ROWS-1-r) and the one after it
   // older sample of the pair in the low words
   always_comb begin
      frame_next = '0;
      for (int r = 0; r < ROWS; r++) begin
         for (int k = 0; k < WPS; k++) begin
            frame_next[r][k + WPS] =
               {hist[SPR*(ROWS-1-r)][LPW*k +: LPW], 1'b0};
            frame_next[r][k] =
               {hist[SPR*(ROWS-1-r) + 1][LPW*k +: LPW], 1'b0};
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // output registers
   ////////////////////////////////////////////////////////////////////////////
   // words hold between loads, rst_retime does not reach them
   always_ff @(posedge clk or negedge arstb) begin
      if (!arstb) begin
         frame_words <= '0;
      end else if (frame_load) begin
         frame_words <= frame_next;
      end
   end

   // one cycle pulse marking fresh words
   always_ff @(posedge clk or negedge arstb) begin
      if (!arstb) begin
         frame_strobe <= 1'b0;
      end else begin
         frame_strobe <= frame_load;
      end
   end

endmodule

`default_nettype wire

// File: hdl/lvds_retime_top.sv
////////////////////////////////////////////////////////////////////////////
// lvds capture retimer top level
// sampler, history and packer stages
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lvds_retime_top #(
   parameter int LANE_COUNT = lvds_retime_pkg::LANE_COUNT,
   parameter int HISTORY_DEPTH = lvds_retime_pkg::HISTORY_DEPTH
) (
   input  wire                         clk,
   input  wire                         arstb,
   input  wire                         rst_retime,
   input  wire lvds_retime_pkg::lane_vec_t lanes,
   output lvds_retime_pkg::frame_words_t frame_words,
   output logic                        frame_strobe
);

   ////////////////////////////////////////////////////////////////////////////
   // geometry checks
   ////////////////////////////////////////////////////////////////////////////
   // lanes must split into whole words
   if (LANE_COUNT % lvds_retime_pkg::LANES_PER_WORD != 0) begin : g_lane_chk
      $error("LANE_COUNT must be a multiple of LANES_PER_WORD");
   end

   // port types are sized from the package
   if (LANE_COUNT != $bits(lvds_retime_pkg::lane_vec_t)) begin : g_width_chk
      $error("LANE_COUNT does not match the lane vector width");
   end

   // history fills whole rows of two samples
   if (HISTORY_DEPTH < 2 || HISTORY_DEPTH % 2 != 0) begin : g_depth_chk
      $error("HISTORY_DEPTH must be even and at least 2");
   end

   if (HISTORY_DEPTH / lvds_retime_pkg::SAMPLES_PER_ROW
       != lvds_retime_pkg::ROW_COUNT) begin : g_row_chk
      $error("HISTORY_DEPTH does not match the frame row count");
   end

   lvds_retime_pkg::lane_vec_t                     sample_new;
   lvds_retime_pkg::lane_vec_t [1:HISTORY_DEPTH-1] sample_old;
   logic                                           frame_load;

   ////////////////////////////////////////////////////////////////////////////
   // stages
   ////////////////////////////////////////////////////////////////////////////
   lane_sampler u_lane_sampler (
      .clk        (clk),
      .arstb      (arstb),
      .rst_retime (rst_retime),
      .lanes      (lanes),
      .sample_new (sample_new),
      .frame_load (frame_load)
   );

   sample_history #(
      .HISTORY_DEPTH (HISTORY_DEPTH)
   ) u_sample_history (
      .clk        (clk),
      .arstb      (arstb),
      .rst_retime (rst_retime),
      .sample_new (sample_new),
      .sample_old (sample_old)
   );

   frame_packer #(
      .HISTORY_DEPTH (HISTORY_DEPTH)
   ) u_frame_packer (
      .clk          (clk),
      .arstb        (arstb),
      .sample_new   (sample_new),
      .sample_old   (sample_old),
      .frame_load   (frame_load),
      .frame_words  (frame_words),
      .frame_strobe (frame_strobe)
   );

endmodule

`default_nettype wire

// File: verification/lvds_retime_asserts.sv
////////////////////////////////////////////////////////////////////////////
// concurrent checks on frame phase, frame strobe and retime clear
// failure count read by the testbench
// bind statements for the sampler and the packer
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lvds_retime_asserts #(
   parameter bit PHASE_CHECKS  = 1'b1,
   parameter bit STROBE_CHECKS = 1'b1
) (
   input wire                             clk,
   input wire                             arstb,
   input wire                             rst_retime,
   input wire lvds_retime_pkg::lane_vec_t sample_new,
   input wire                             frame_load,
   input wire                             frame_strobe
);

   localparam int FRAME_CYCLES = lvds_retime_pkg::FRAME_CYCLES;

   // assertion failures so far
   int fail_count = 0;

   if (PHASE_CHECKS) begin : g_phase
      // clocks since the last load or clear
      int since_load;

      always_ff @(posedge clk or negedge arstb) begin
         if (!arstb) begin
            since_load <= 0;
         end else if (!rst_retime || frame_load) begin
            since_load <= 0;
         end else begin
            since_load <= since_load + 1;
         end
      end

      load_period: assert property (@(posedge clk) disable iff (!arstb)
         frame_load == (since_load == FRAME_CYCLES - 1))
         else begin
            fail_count++;
            $error("frame_load out of step with the frame period");
         end

      clear_sample: assert property (@(posedge clk) disable iff (!arstb)
         !rst_retime |=> sample_new == '0)
         else begin
            fail_count++;
            $error("sample_new not zero one cycle after rst_retime low");
         end
   end

   if (STROBE_CHECKS) begin : g_strobe
      strobe_single: assert property (@(posedge clk) disable iff (!arstb)
         frame_strobe |=> !frame_strobe)
         else begin
            fail_count++;
            $error("frame_strobe high for two cycles in a row");
         end
   end

endmodule

// phase and clear checks live next to the sampler
bind lane_sampler lvds_retime_asserts #(
   .PHASE_CHECKS  (1'b1),
   .STROBE_CHECKS (1'b0)
) sampler_asserts_i (
   .clk          (clk),
   .arstb        (arstb),
   .rst_retime   (rst_retime),
   .sample_new   (sample_new),
   .frame_load   (frame_load),
   .frame_strobe (1'b0)
);

bind frame_packer lvds_retime_asserts #(
   .PHASE_CHECKS  (1'b0),
   .STROBE_CHECKS (1'b1)
) packer_asserts_i (
   .clk          (clk),
   .arstb        (arstb),
   .rst_retime   (1'b1),
   .sample_new   (sample_new),
   .frame_load   (frame_load),
   .frame_strobe (frame_strobe)
);

`default_nettype wire

// File: verification/lvds_retime_tb.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the lvds capture retimer
// clock, reset, stimulus table and lfsr lane data
// reference history model and per cycle output checks
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lvds_retime_tb;

   localparam int LANES = lvds_retime_pkg::LANE_COUNT;
   localparam int DEPTH = lvds_retime_pkg::HISTORY_DEPTH;
   localparam int ROWS = lvds_retime_pkg::ROW_COUNT;
   localparam int WPR = lvds_retime_pkg::WORDS_PER_ROW;
   localparam int LPW = lvds_retime_pkg::LANES_PER_WORD;
   localparam int FRAME = lvds_retime_pkg::FRAME_CYCLES;
   localparam int STROBE_TIMEOUT = 20;
   localparam int NTESTS = 6;

   localparam int MODE_CONST = 0;
   localparam int MODE_WALK = 1;
   localparam int MODE_RAND = 2;

   logic                           clk;
   logic                           arstb;
   logic                           rst_retime;
   lvds_retime_pkg::lane_vec_t     lanes;
   lvds_retime_pkg::frame_words_t  frame_words;
   logic                           frame_strobe;

   ////////////////////////////////////////////////////////////////////////////
   // stimulus table
   ////////////////////////////////////////////////////////////////////////////
   string test_name [NTESTS] = '{"reset_idle", "first_strobe", "walking_one",
                                 "random_frames", "clear_pulse", "random_tail"};
   int test_mode [NTESTS] = '{MODE_CONST, MODE_CONST, MODE_WALK,
                              MODE_RAND, MODE_RAND, MODE_RAND};
   lvds_retime_pkg::lane_vec_t test_value [NTESTS] = '{20'hFFFFF, 20'hA5C3E,
                                                       '0, '0, '0, '0};
   int test_len [NTESTS] = '{16, 12, 40, 200, 30, 60};
   // cycle with rst_retime pulsed low or -1 for none
   int test_pulse [NTESTS] = '{-1, -1, -1, -1, 13, -1};
   // rst_retime held low for the whole test
   bit test_hold [NTESTS] = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};

   // reference model with the newest sample at index 0
   lvds_retime_pkg::lane_vec_t    model_hist [DEPTH];
   int                            model_phase;
   lvds_retime_pkg::frame_words_t model_words;
   logic                          model_strobe;
   lvds_retime_pkg::lane_vec_t    last_lanes;
   logic                          last_rst;

   logic [15:0] lfsr_state;
   string       cur_name;
   int          gap;
   bit          first_after_clear;
   int          err_count;
   int          test_errs;
   bit          timed_out;

   lvds_retime_top #(
      .LANE_COUNT    (LANES),
      .HISTORY_DEPTH (DEPTH)
   ) dut_i (
      .clk          (clk),
      .arstb        (arstb),
      .rst_retime   (rst_retime),
      .lanes        (lanes),
      .frame_words  (frame_words),
      .frame_strobe (frame_strobe)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // lane data
   ////////////////////////////////////////////////////////////////////////////
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      logic [15:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ 16'hB400;
      end
      return n;
   endfunction

   function automatic lvds_retime_pkg::lane_vec_t random_lanes();
      lvds_retime_pkg::lane_vec_t v;
      for (int b = 0; b < LANES; b++) begin
         v[b] = lfsr_state[0];
         lfsr_state = lfsr_next(lfsr_state);
      end
      return v;
   endfunction

   function automatic lvds_retime_pkg::lane_vec_t lane_pattern(input int t, input int c);
      lvds_retime_pkg::lane_vec_t v;
      v = '0;
      case (test_mode[t])
         MODE_WALK: v[c % LANES] = 1'b1;
         MODE_RAND: v = random_lanes();
         default:   v = test_value[t];
      endcase
      return v;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // reference model
   ////////////////////////////////////////////////////////////////////////////
   // even samples go to the upper half of their row with lane bits from bit 1
   function automatic lvds_retime_pkg::frame_words_t pack_history();
      lvds_retime_pkg::frame_words_t f;
      int row;
      int word;
      f = '0;
      for (int s = 0; s < DEPTH; s++) begin
         for (int l = 0; l < LANES; l++) begin
            row = ROWS - 1 - s / 2;
            word = (s % 2 == 0) ? WPR / 2 + l / LPW : l / LPW;
            f[row][word][1 + l % LPW] = model_hist[s][l];
         end
      end
      return f;
   endfunction

   // applies the rising edge that has just passed
   task automatic model_edge();
      model_strobe = (model_phase == FRAME - 1);
      if (model_strobe) begin
         model_words = pack_history();
      end
      if (!last_rst) begin
         for (int i = 0; i < DEPTH; i++) begin
            model_hist[i] = '0;
         end
         model_phase = 0;
      end else begin
         for (int i = DEPTH - 1; i > 0; i--) begin
            model_hist[i] = model_hist[i-1];
         end
         model_hist[0] = last_lanes;
         model_phase = model_strobe ? 0 : model_phase + 1;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // checks
   ////////////////////////////////////////////////////////////////////////////
   task automatic log_mismatch(input string what, input string expected,
                               input string actual);
      err_count++;
      test_errs++;
      $display("ERROR %s %s expected %s actual %s", cur_name, what, expected, actual);
   endtask

   task automatic check_outputs();
      assert (frame_strobe === model_strobe) else
         log_mismatch("frame_strobe", $sformatf("%b", model_strobe),
                      $sformatf("%b", frame_strobe));
      assert (frame_words === model_words) else
         log_mismatch("frame_words", $sformatf("%h", model_words),
                      $sformatf("%h", frame_words));
      gap++;
      if (frame_strobe === 1'b1) begin
         for (int r = 0; r < ROWS; r++) begin
            for (int w = 0; w < WPR; w++) begin
               assert (frame_words[r][w][0] === 1'b0) else
                  log_mismatch($sformatf("pad bit row %0d word %0d", r, w), "0",
                               $sformatf("%b", frame_words[r][w][0]));
            end
         end
         assert (gap == FRAME) else
            log_mismatch(first_after_clear ? "first strobe delay" : "strobe interval",
                         $sformatf("%0d", FRAME), $sformatf("%0d", gap));
         gap = 0;
         first_after_clear = 1'b0;
      end
      if (!last_rst) begin
         gap = 0;
         first_after_clear = 1'b1;
      end
   endtask

   // model and check the edge just passed and then drive the next inputs
   task automatic step(input lvds_retime_pkg::lane_vec_t next_lanes, input logic next_rst);
      @(negedge clk);
      model_edge();
      check_outputs();
      lanes = next_lanes;
      rst_retime = next_rst;
      last_lanes = next_lanes;
      last_rst = next_rst;
   endtask

   task automatic wait_strobe(input int t, input int start);
      int waited;
      bit seen;
      waited = 0;
      seen = 1'b0;
      while (!seen && waited < STROBE_TIMEOUT) begin
         step(lane_pattern(t, start + waited), 1'b1);
         waited++;
         seen = (frame_strobe === 1'b1);
      end
      if (!seen) begin
         timed_out = 1'b1;
         $display("no frame_strobe within %0d cycles at the end of test %s",
                  STROBE_TIMEOUT, cur_name);
      end
   endtask

   task automatic run_test(input int t);
      logic rst_val;
      cur_name = test_name[t];
      test_errs = 0;
      for (int c = 0; c < test_len[t]; c++) begin
         rst_val = !(test_hold[t] || c == test_pulse[t]);
         step(lane_pattern(t, c), rst_val);
         if (test_hold[t]) begin
            assert (frame_words === '0 && frame_strobe === 1'b0) else
               log_mismatch("idle outputs", "all zero",
                            $sformatf("%h strobe %b", frame_words, frame_strobe));
         end
      end
      if (!test_hold[t]) begin
         wait_strobe(t, test_len[t]);
      end
      $display("%-14s %4d cycles  %0d errors%s", cur_name, test_len[t], test_errs,
               timed_out ? "  timed out" : "");
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////////////////////
   initial begin
      int t;
      int failed_tests;
      int assert_fails;
      arstb = 1'b0;
      rst_retime = 1'b0;
      lanes = '0;
      lfsr_state = 16'd64305;
      for (int i = 0; i < DEPTH; i++) begin
         model_hist[i] = '0;
      end
      model_phase = 0;
      model_words = '0;
      model_strobe = 1'b0;
      last_lanes = '0;
      last_rst = 1'b0;
      gap = 0;
      first_after_clear = 1'b1;
      err_count = 0;
      timed_out = 1'b0;
      failed_tests = 0;

      repeat (5) @(posedge clk);
      @(negedge clk);
      arstb = 1'b1;

      for (t = 0; t < NTESTS && !timed_out; t++) begin
         run_test(t);
         if (test_errs != 0 || timed_out) begin
            failed_tests++;
         end
      end

      // failures of the bound concurrent checks
      assert_fails = dut_i.u_lane_sampler.sampler_asserts_i.fail_count
                     + dut_i.u_frame_packer.packer_asserts_i.fail_count;

      $display("%0d tests run, %0d failed, %0d errors, %0d assertion failures",
               t, failed_tests, err_count, assert_fails);
      if (err_count == 0 && assert_fails == 0 && !timed_out) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: all.f
hdl/lvds_retime_pkg.sv
hdl/lane_sampler.sv
hdl/sample_history.sv
hdl/frame_packer.sv
hdl/lvds_retime_top.sv
verification/lvds_retime_asserts.sv
verification/lvds_retime_tb.sv

// File: run.sh
#!/bin/sh
# builds and runs the lvds retimer testbench with verilator

cd "$(dirname "$0")" || exit 1

TOP=lvds_retime_tb
LOG=sim.log

verilator --binary --timing --assert --top-module "$TOP" -f all.f
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$LOG"; then
   exit 0
fi

echo "pass message not found in $LOG"
exit 1
